// File: common/soc_pkg.sv
// shared types, address map, register offsets and route encodings for the fabric and testbench
package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  localparam int GPIO_W = 16;
  typedef logic [GPIO_W-1:0] gpio_t;

  localparam int IRQ_W = 32;
  typedef logic [IRQ_W-1:0] irq_t;

  // pad routing selector, off leaves the pads as plain gpio
  typedef logic [1:0] route_t;
  localparam route_t ROUTE_OFF  = 2'd0;
  localparam route_t ROUTE_SEL1 = 2'd1;
  localparam route_t ROUTE_SEL2 = 2'd2;
  localparam route_t ROUTE_SEL3 = 2'd3;

  // word address bits on the external ram port
  localparam int RAM_ADDR_W = 15;

  // system control window is 256 bytes
  localparam addr_t SYSCTRL_BASE  = 32'h0300_0000;
  localparam int    SYSCTRL_WIN_W = 8;
  typedef logic [SYSCTRL_WIN_W-1:0] reg_ofs_t;

  localparam reg_ofs_t GPIO_DATA_OFS = 8'h00;
  localparam reg_ofs_t GPIO_OEB_OFS  = 8'h04;
  localparam reg_ofs_t GPIO_PU_OFS   = 8'h08;
  localparam reg_ofs_t GPIO_PD_OFS   = 8'h0C;
  localparam reg_ofs_t MFGR_ID_OFS   = 8'h24;
  localparam reg_ofs_t PROD_ID_OFS   = 8'h28;
  localparam reg_ofs_t MASK_REV_OFS  = 8'h2C;
  localparam reg_ofs_t CLK_SEL_OFS   = 8'h30;
  localparam reg_ofs_t PLL_DEST_OFS  = 8'h38;
  localparam reg_ofs_t TRAP_DEST_OFS = 8'h3C;
  localparam reg_ofs_t IRQ7_SRC_OFS  = 8'h40;
  localparam reg_ofs_t IRQ8_SRC_OFS  = 8'h44;

  // interrupt vector positions
  localparam int IRQ_PIN_BIT   = 5;
  localparam int IRQ_SPI_BIT   = 6;
  localparam int IRQ_GPIO7_BIT = 7;
  localparam int IRQ_GPIO8_BIT = 8;

endpackage

// File: common/mem_bus_if.sv
// native valid/ready memory bus between the address decoder and a register device
interface mem_bus_if import soc_pkg::*; ();

  logic  valid;
  addr_t addr;
  data_t wdata;
  strb_t wstrb;
  logic  ready;
  data_t rdata;

  // request side
  modport host (
    output valid,
    output addr,
    output wdata,
    output wstrb,
    input  ready,
    input  rdata
  );

  // response side, ready is a one cycle pulse
  modport device (
    input  valid,
    input  addr,
    input  wdata,
    input  wstrb,
    output ready,
    output rdata
  );

endinterface

// File: sysctrl/sysctrl_regs.sv
// system control register file on the fabric bus, answers every access one cycle after valid
module sysctrl_regs import soc_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  mem_bus_if.device   bus,
  input  gpio_t       gpio_in_i,
  input  gpio_t       pad_out_i,
  input  logic        clk_ext_sel_i,
  input  logic [11:0] mfgr_id_i,
  input  logic [7:0]  prod_id_i,
  input  logic [3:0]  mask_rev_i,
  output gpio_t       gpio_reg_o,
  output gpio_t       oeb_reg_o,
  output gpio_t       pu_reg_o,
  output gpio_t       pd_reg_o,
  output route_t      pll_dest_o,
  output route_t      trap_dest_o,
  output route_t      irq7_src_o,
  output route_t      irq8_src_o
);

  reg_ofs_t s_ofs;
  data_t    s_rdata;
  logic     r_ready;
  data_t    r_rdata;
  gpio_t    r_gpio;
  gpio_t    r_oeb;
  gpio_t    r_pu;
  gpio_t    r_pd;
  route_t   r_pll_dest;
  route_t   r_trap_dest;
  route_t   r_irq7_src;
  route_t   r_irq8_src;

  // lanes 0 and 1 cover a 16-bit register, empty strobe keeps it
  function automatic gpio_t lane_merge(input gpio_t cur, input data_t wdata, input strb_t wstrb);
    gpio_t res;
    res = cur;
    if (wstrb[0]) res[7:0] = wdata[7:0];
    if (wstrb[1]) res[15:8] = wdata[15:8];
    return res;
  endfunction

  assign s_ofs = bus.addr[SYSCTRL_WIN_W-1:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_ready     <= 1'b0;
      r_gpio      <= '0;
      r_oeb       <= '1;
      r_pu        <= '0;
      r_pd        <= '0;
      r_pll_dest  <= ROUTE_OFF;
      r_trap_dest <= ROUTE_OFF;
      r_irq7_src  <= ROUTE_OFF;
      r_irq8_src  <= ROUTE_OFF;
    end else begin
      r_ready <= bus.valid;
      if (bus.valid) begin
        case (s_ofs)
          GPIO_DATA_OFS: r_gpio <= lane_merge(r_gpio, bus.wdata, bus.wstrb);
          GPIO_OEB_OFS:  r_oeb  <= lane_merge(r_oeb, bus.wdata, bus.wstrb);
          GPIO_PU_OFS:   r_pu   <= lane_merge(r_pu, bus.wdata, bus.wstrb);
          GPIO_PD_OFS:   r_pd   <= lane_merge(r_pd, bus.wdata, bus.wstrb);
          // selectors only on lane 0
          PLL_DEST_OFS:  if (bus.wstrb[0]) r_pll_dest <= bus.wdata[1:0];
          TRAP_DEST_OFS: if (bus.wstrb[0]) r_trap_dest <= bus.wdata[1:0];
          IRQ7_SRC_OFS:  if (bus.wstrb[0]) r_irq7_src <= bus.wdata[1:0];
          IRQ8_SRC_OFS:  if (bus.wstrb[0]) r_irq8_src <= bus.wdata[1:0];
          default: ;
        endcase
      end
    end
  end

  // read value is the state before any write in the same access
  always_comb begin
    case (s_ofs)
      GPIO_DATA_OFS: s_rdata = {pad_out_i, gpio_in_i};
      GPIO_OEB_OFS:  s_rdata = data_t'(r_oeb);
      GPIO_PU_OFS:   s_rdata = data_t'(r_pu);
      GPIO_PD_OFS:   s_rdata = data_t'(r_pd);
      MFGR_ID_OFS:   s_rdata = data_t'(mfgr_id_i);
      PROD_ID_OFS:   s_rdata = data_t'(prod_id_i);
      MASK_REV_OFS:  s_rdata = data_t'(mask_rev_i);
      CLK_SEL_OFS:   s_rdata = data_t'(clk_ext_sel_i);
      PLL_DEST_OFS:  s_rdata = data_t'(r_pll_dest);
      TRAP_DEST_OFS: s_rdata = data_t'(r_trap_dest);
      IRQ7_SRC_OFS:  s_rdata = data_t'(r_irq7_src);
      IRQ8_SRC_OFS:  s_rdata = data_t'(r_irq8_src);
      default:       s_rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.valid) begin
      r_rdata <= s_rdata;
    end
  end

  assign bus.ready = r_ready;
  assign bus.rdata = r_rdata;

  assign gpio_reg_o  = r_gpio;
  assign oeb_reg_o   = r_oeb;
  assign pu_reg_o    = r_pu;
  assign pd_reg_o    = r_pd;
  assign pll_dest_o  = r_pll_dest;
  assign trap_dest_o = r_trap_dest;
  assign irq7_src_o  = r_irq7_src;
  assign irq8_src_o  = r_irq8_src;

endmodule

// File: sysctrl/gpio_pad_mux.sv
// pad override logic for clock and trap routing plus the two gpio interrupt selectors
module gpio_pad_mux import soc_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   trap_i,
  input  gpio_t  gpio_in_i,
  input  gpio_t  gpio_reg_i,
  input  gpio_t  oeb_reg_i,
  input  gpio_t  pu_reg_i,
  input  gpio_t  pd_reg_i,
  input  route_t pll_dest_i,
  input  route_t trap_dest_i,
  input  route_t irq7_src_i,
  input  route_t irq8_src_i,
  output gpio_t  gpio_out_o,
  output gpio_t  gpio_outenb_o,
  output gpio_t  gpio_pullupb_o,
  output gpio_t  gpio_pulldownb_o,
  output logic   irq7_o,
  output logic   irq8_o
);

  // each routed group spans three pads
  localparam int GROUP_W   = 3;
  localparam int PLL_PAD0  = 8;
  localparam int TRAP_PAD0 = 11;
  localparam int IRQ7_PIN0 = 0;
  localparam int IRQ8_PIN0 = 3;

  gpio_t s_oeb;

  // source n picks input base+n-1, off gives zero
  function automatic logic pick_input(input gpio_t pins, input route_t src, input int base);
    logic res;
    res = 1'b0;
    if (src != ROUTE_OFF) res = pins[base+int'(src)-1];
    return res;
  endfunction

  always_comb begin
    gpio_out_o       = gpio_reg_i;
    s_oeb            = oeb_reg_i;
    gpio_pullupb_o   = pu_reg_i;
    gpio_pulldownb_o = pd_reg_i;

    // routed groups drive out with both pulls off
    if (pll_dest_i != ROUTE_OFF) begin
      s_oeb[PLL_PAD0 +: GROUP_W]            = '0;
      gpio_pullupb_o[PLL_PAD0 +: GROUP_W]   = '1;
      gpio_pulldownb_o[PLL_PAD0 +: GROUP_W] = '1;
    end
    if (trap_dest_i != ROUTE_OFF) begin
      s_oeb[TRAP_PAD0 +: GROUP_W]            = '0;
      gpio_pullupb_o[TRAP_PAD0 +: GROUP_W]   = '1;
      gpio_pulldownb_o[TRAP_PAD0 +: GROUP_W] = '1;
      gpio_out_o[TRAP_PAD0+int'(trap_dest_i)-1] = trap_i;
    end

    // third pll destination claims the group but carries no clock
    case (pll_dest_i)
      ROUTE_SEL1: gpio_out_o[PLL_PAD0]   = clk_i;
      ROUTE_SEL2: gpio_out_o[PLL_PAD0+1] = clk_i;
      default: ;
    endcase
  end

  // pads stay tristate throughout reset
  assign gpio_outenb_o = s_oeb | {GPIO_W{~rst_n_i}};

  assign irq7_o = pick_input(gpio_in_i, irq7_src_i, IRQ7_PIN0);
  assign irq8_o = pick_input(gpio_in_i, irq8_src_i, IRQ8_PIN0);

endmodule

// File: verilog/mem_decoder.sv
// address decoder steering host requests to sram, system control or the unmapped responder
module mem_decoder import soc_pkg::*; #(
  parameter int MEM_WORDS = 32768
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  mem_valid_i,
  input  addr_t                 mem_addr_i,
  input  data_t                 mem_wdata_i,
  input  strb_t                 mem_wstrb_i,
  output logic                  mem_ready_o,
  output data_t                 mem_rdata_o,
  output strb_t                 ram_wstrb_o,
  output logic [RAM_ADDR_W-1:0] ram_addr_o,
  output data_t                 ram_wdata_o,
  input  data_t                 ram_rdata_i,
  mem_bus_if.host               sys_bus
);

  // ram occupies bytes 0 to 4*MEM_WORDS
  localparam addr_t RAM_LIMIT = addr_t'(4 * MEM_WORDS);

  logic s_start;
  logic s_ram_hit;
  logic s_sys_hit;
  logic s_unmap_hit;
  logic r_ram_ready;
  logic r_unmap_ready;

  // no new start while the current response is on the bus
  assign s_start     = mem_valid_i && !mem_ready_o;
  assign s_ram_hit   = mem_addr_i < RAM_LIMIT;
  assign s_sys_hit   = !s_ram_hit &&
                       (mem_addr_i[31:SYSCTRL_WIN_W] == SYSCTRL_BASE[31:SYSCTRL_WIN_W]);
  assign s_unmap_hit = !s_ram_hit && !s_sys_hit;

  // sram strobe only in the request cycle
  assign ram_wstrb_o = (s_start && s_ram_hit) ? mem_wstrb_i : '0;
  assign ram_addr_o  = mem_addr_i[RAM_ADDR_W+1:2];
  assign ram_wdata_o = mem_wdata_i;

  assign sys_bus.valid = s_start && s_sys_hit;
  assign sys_bus.addr  = mem_addr_i;
  assign sys_bus.wdata = mem_wdata_i;
  assign sys_bus.wstrb = mem_wstrb_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_ram_ready   <= 1'b0;
      r_unmap_ready <= 1'b0;
    end else begin
      r_ram_ready   <= s_start && s_ram_hit;
      r_unmap_ready <= s_start && s_unmap_hit;
    end
  end

  assign mem_ready_o = r_ram_ready || r_unmap_ready || sys_bus.ready;

  // unmapped reads fall through to zero
  assign mem_rdata_o = sys_bus.ready ? sys_bus.rdata :
                       r_ram_ready   ? ram_rdata_i   :
                       '0;

endmodule

// File: verilog/soc_fabric_top.sv
// top level of the memory fabric, the host bus and all pads are plain ports here
module soc_fabric_top import soc_pkg::*; #(
  parameter int MEM_WORDS = 32768
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // host bus
  input  logic                  mem_valid_i,
  input  addr_t                 mem_addr_i,
  input  data_t                 mem_wdata_i,
  input  strb_t                 mem_wstrb_i,
  output logic                  mem_ready_o,
  output data_t                 mem_rdata_o,
  // external sram
  output strb_t                 ram_wstrb_o,
  output logic [RAM_ADDR_W-1:0] ram_addr_o,
  output data_t                 ram_wdata_o,
  input  data_t                 ram_rdata_i,
  // pads
  input  gpio_t                 gpio_in_i,
  output gpio_t                 gpio_out_o,
  output gpio_t                 gpio_outenb_o,
  output gpio_t                 gpio_pullupb_o,
  output gpio_t                 gpio_pulldownb_o,
  // interrupts and status
  input  logic                  trap_i,
  input  logic                  irq_pin_i,
  input  logic                  irq_spi_i,
  input  logic                  clk_ext_sel_i,
  input  logic [11:0]           mfgr_id_i,
  input  logic [7:0]            prod_id_i,
  input  logic [3:0]            mask_rev_i,
  output irq_t                  irq_o
);

  gpio_t  s_gpio_reg;
  gpio_t  s_oeb_reg;
  gpio_t  s_pu_reg;
  gpio_t  s_pd_reg;
  route_t s_pll_dest;
  route_t s_trap_dest;
  route_t s_irq7_src;
  route_t s_irq8_src;
  logic   s_irq7;
  logic   s_irq8;

  mem_bus_if sys_bus ();

  mem_decoder #(
    .MEM_WORDS(MEM_WORDS)
  ) u_mem_decoder (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mem_valid_i(mem_valid_i),
    .mem_addr_i (mem_addr_i),
    .mem_wdata_i(mem_wdata_i),
    .mem_wstrb_i(mem_wstrb_i),
    .mem_ready_o(mem_ready_o),
    .mem_rdata_o(mem_rdata_o),
    .ram_wstrb_o(ram_wstrb_o),
    .ram_addr_o (ram_addr_o),
    .ram_wdata_o(ram_wdata_o),
    .ram_rdata_i(ram_rdata_i),
    .sys_bus    (sys_bus.host)
  );

  sysctrl_regs u_sysctrl_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bus          (sys_bus.device),
    .gpio_in_i    (gpio_in_i),
    .pad_out_i    (gpio_out_o),
    .clk_ext_sel_i(clk_ext_sel_i),
    .mfgr_id_i    (mfgr_id_i),
    .prod_id_i    (prod_id_i),
    .mask_rev_i   (mask_rev_i),
    .gpio_reg_o   (s_gpio_reg),
    .oeb_reg_o    (s_oeb_reg),
    .pu_reg_o     (s_pu_reg),
    .pd_reg_o     (s_pd_reg),
    .pll_dest_o   (s_pll_dest),
    .trap_dest_o  (s_trap_dest),
    .irq7_src_o   (s_irq7_src),
    .irq8_src_o   (s_irq8_src)
  );

  gpio_pad_mux u_gpio_pad_mux (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .trap_i          (trap_i),
    .gpio_in_i       (gpio_in_i),
    .gpio_reg_i      (s_gpio_reg),
    .oeb_reg_i       (s_oeb_reg),
    .pu_reg_i        (s_pu_reg),
    .pd_reg_i        (s_pd_reg),
    .pll_dest_i      (s_pll_dest),
    .trap_dest_i     (s_trap_dest),
    .irq7_src_i      (s_irq7_src),
    .irq8_src_i      (s_irq8_src),
    .gpio_out_o      (gpio_out_o),
    .gpio_outenb_o   (gpio_outenb_o),
    .gpio_pullupb_o  (gpio_pullupb_o),
    .gpio_pulldownb_o(gpio_pulldownb_o),
    .irq7_o          (s_irq7),
    .irq8_o          (s_irq8)
  );

  // sources outside this fabric stay zero
  always_comb begin
    irq_o                = '0;
    irq_o[IRQ_PIN_BIT]   = irq_pin_i;
    irq_o[IRQ_SPI_BIT]   = irq_spi_i;
    irq_o[IRQ_GPIO7_BIT] = s_irq7;
    irq_o[IRQ_GPIO8_BIT] = s_irq8;
  end

endmodule

// File: verif/tb_soc_fabric.sv
// testbench that runs host bus accesses and pad stimulus on soc_fabric_top against a reference model
module tb_soc_fabric import soc_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_WORDS  = 32768;
  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 16;
  localparam int N_REG      = 32;
  localparam int N_RAM      = 16;
  localparam int N_ACCESS   = 7 + 2 * N_REG + 2 * N_RAM + 9 + 8 + 9;
  // each access takes two bus cycles and one idle cycle, plus margin
  localparam int WATCHDOG_CYCLES = RST_CYCLES + 2 * N_ACCESS + N_ACCESS + 100;

  logic clk_i, rst_n_i, mem_valid_i, mem_ready_o;
  addr_t mem_addr_i;
  data_t mem_wdata_i, mem_rdata_o, ram_wdata_o, ram_rdata_i;
  strb_t mem_wstrb_i, ram_wstrb_o;
  logic [RAM_ADDR_W-1:0] ram_addr_o;
  gpio_t gpio_in_i, gpio_out_o, gpio_outenb_o, gpio_pullupb_o, gpio_pulldownb_o;
  logic trap_i, irq_pin_i, irq_spi_i, clk_ext_sel_i;
  logic [11:0] mfgr_id_i;
  logic [7:0] prod_id_i;
  logic [3:0] mask_rev_i;
  irq_t irq_o;

  // reference model state
  gpio_t exp_gpio, exp_oeb, exp_pu, exp_pd;
  route_t exp_pll, exp_trap, exp_irq7, exp_irq8;
  data_t exp_ram [int];
  data_t ram_mem [int];

  logic [31:0] rng;
  gpio_t next_gin;
  strb_t seen_wstrb, ready_wstrb;
  logic [RAM_ADDR_W-1:0] seen_raddr;
  data_t last_rdata;
  int value_errors = 0;
  int proto_errors = 0;
  string name_q[$];
  data_t exp_q[$];
  data_t act_q[$];

  soc_fabric_top #(
    .MEM_WORDS(MEM_WORDS)
  ) u_soc_fabric_top (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .mem_valid_i(mem_valid_i), .mem_addr_i(mem_addr_i), .mem_wdata_i(mem_wdata_i),
    .mem_wstrb_i(mem_wstrb_i), .mem_ready_o(mem_ready_o), .mem_rdata_o(mem_rdata_o),
    .ram_wstrb_o(ram_wstrb_o), .ram_addr_o(ram_addr_o), .ram_wdata_o(ram_wdata_o),
    .ram_rdata_i(ram_rdata_i), .gpio_in_i(gpio_in_i), .gpio_out_o(gpio_out_o),
    .gpio_outenb_o(gpio_outenb_o), .gpio_pullupb_o(gpio_pullupb_o),
    .gpio_pulldownb_o(gpio_pulldownb_o), .trap_i(trap_i), .irq_pin_i(irq_pin_i),
    .irq_spi_i(irq_spi_i), .clk_ext_sel_i(clk_ext_sel_i), .mfgr_id_i(mfgr_id_i),
    .prod_id_i(prod_id_i), .mask_rev_i(mask_rev_i), .irq_o(irq_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // unwritten sram words hold a pattern built from the whole word address
  function automatic data_t ram_fill(input logic [RAM_ADDR_W-1:0] w);
    return {w, 2'b10, w};
  endfunction

  function automatic data_t byte_merge(input data_t cur, input data_t wdata, input strb_t wstrb);
    data_t res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  function automatic gpio_t lanes16(input gpio_t cur, input data_t wdata, input strb_t wstrb);
    data_t t;
    t = byte_merge({16'h0, cur}, wdata, wstrb & 4'b0011);
    return t[15:0];
  endfunction

  function automatic void model_write(input addr_t addr, input data_t wdata, input strb_t wstrb);
    logic [RAM_ADDR_W-1:0] w;
    w = addr[RAM_ADDR_W+1:2];
    if (addr < 4 * MEM_WORDS) begin
      exp_ram[w] = byte_merge(exp_ram.exists(w) ? exp_ram[w] : ram_fill(w), wdata, wstrb);
    end else if (addr[31:8] == SYSCTRL_BASE[31:8]) begin
      case (addr[7:0])
        GPIO_DATA_OFS: exp_gpio = lanes16(exp_gpio, wdata, wstrb);
        GPIO_OEB_OFS:  exp_oeb = lanes16(exp_oeb, wdata, wstrb);
        GPIO_PU_OFS:   exp_pu = lanes16(exp_pu, wdata, wstrb);
        GPIO_PD_OFS:   exp_pd = lanes16(exp_pd, wdata, wstrb);
        PLL_DEST_OFS:  if (wstrb[0]) exp_pll = wdata[1:0];
        TRAP_DEST_OFS: if (wstrb[0]) exp_trap = wdata[1:0];
        IRQ7_SRC_OFS:  if (wstrb[0]) exp_irq7 = wdata[1:0];
        IRQ8_SRC_OFS:  if (wstrb[0]) exp_irq8 = wdata[1:0];
        default: ;
      endcase
    end
  endfunction

  function automatic void ref_pads(input logic clk_lvl, input logic trap_lvl, output gpio_t out,
                                   output gpio_t oeb, output gpio_t pu, output gpio_t pd);
    out = exp_gpio;
    oeb = exp_oeb;
    pu = exp_pu;
    pd = exp_pd;
    if (exp_pll != ROUTE_OFF) begin
      oeb[10:8] = 3'b000;
      pu[10:8] = 3'b111;
      pd[10:8] = 3'b111;
    end
    if (exp_pll == ROUTE_SEL1) out[8] = clk_lvl;
    if (exp_pll == ROUTE_SEL2) out[9] = clk_lvl;
    if (exp_trap != ROUTE_OFF) begin
      oeb[13:11] = 3'b000;
      pu[13:11] = 3'b111;
      pd[13:11] = 3'b111;
      out[10 + int'(exp_trap)] = trap_lvl;
    end
  endfunction

  function automatic irq_t ref_irq(input gpio_t gin, input logic pin, input logic spi);
    irq_t v;
    v = '0;
    v[IRQ_PIN_BIT] = pin;
    v[IRQ_SPI_BIT] = spi;
    if (exp_irq7 != ROUTE_OFF) v[IRQ_GPIO7_BIT] = gin[int'(exp_irq7) - 1];
    if (exp_irq8 != ROUTE_OFF) v[IRQ_GPIO8_BIT] = gin[int'(exp_irq8) + 2];
    return v;
  endfunction

  function automatic data_t ref_read(input addr_t addr, input gpio_t gin);
    gpio_t out, oeb, pu, pd;
    logic [RAM_ADDR_W-1:0] w;
    data_t v;
    v = '0;
    w = addr[RAM_ADDR_W+1:2];
    if (addr < 4 * MEM_WORDS) begin
      v = exp_ram.exists(w) ? exp_ram[w] : ram_fill(w);
    end else if (addr[31:8] == SYSCTRL_BASE[31:8]) begin
      ref_pads(1'b0, trap_i, out, oeb, pu, pd);
      case (addr[7:0])
        GPIO_DATA_OFS: v = {out, gin};
        GPIO_OEB_OFS:  v = {16'h0, exp_oeb};
        GPIO_PU_OFS:   v = {16'h0, exp_pu};
        GPIO_PD_OFS:   v = {16'h0, exp_pd};
        MFGR_ID_OFS:   v = {20'h0, mfgr_id_i};
        PROD_ID_OFS:   v = {24'h0, prod_id_i};
        MASK_REV_OFS:  v = {28'h0, mask_rev_i};
        CLK_SEL_OFS:   v = {31'h0, clk_ext_sel_i};
        PLL_DEST_OFS:  v = {30'h0, exp_pll};
        TRAP_DEST_OFS: v = {30'h0, exp_trap};
        IRQ7_SRC_OFS:  v = {30'h0, exp_irq7};
        IRQ8_SRC_OFS:  v = {30'h0, exp_irq8};
        default:       v = '0;
      endcase
    end
    return v;
  endfunction

  task automatic post_check(input string name, input data_t exp, input data_t act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  // one request held until ready before valid drops
  task automatic bus_access(input string name, input addr_t addr, input data_t wdata,
                            input strb_t wstrb);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    mem_valid_i <= 1'b1;
    mem_addr_i <= addr;
    mem_wdata_i <= wdata;
    mem_wstrb_i <= wstrb;
    gpio_in_i <= next_gin;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles == 1) begin
        seen_wstrb = ram_wstrb_o;
        seen_raddr = ram_addr_o;
      end
    end while (!mem_ready_o && cycles < 8);
    assert (mem_ready_o) else begin
      proto_errors++;
      $display("no ready for %s within %0d cycles", name, cycles);
    end
    last_rdata = mem_rdata_o;
    ready_wstrb = ram_wstrb_o;
    // valid cycle plus ready cycle
    post_check({name, " latency"}, 32'd2, data_t'(cycles));
    @(posedge clk_i);
    mem_valid_i <= 1'b0;
    mem_wstrb_i <= '0;
    @(negedge clk_i);
    assert (!mem_ready_o) else begin
      proto_errors++;
      $display("ready stayed high for more than one cycle on %s", name);
    end
  endtask

  task automatic do_write(input string name, input addr_t addr, input data_t wdata,
                          input strb_t wstrb);
    bus_access(name, addr, wdata, wstrb);
    model_write(addr, wdata, wstrb);
  endtask

  task automatic do_read(input string name, input addr_t addr);
    data_t exp;
    exp = ref_read(addr, next_gin);
    bus_access(name, addr, 32'h0, 4'h0);
    post_check(name, exp, last_rdata);
  endtask

  // pads follow clk_i combinationally and are sampled a quarter period after the edge
  task automatic check_pads(input string name);
    gpio_t out, oeb, pu, pd;
    #(CLK_PERIOD / 4);
    ref_pads(clk_i, trap_i, out, oeb, pu, pd);
    post_check({name, " out"}, data_t'(out), data_t'(gpio_out_o));
    post_check({name, " oeb"}, data_t'(oeb), data_t'(gpio_outenb_o));
    post_check({name, " pullupb"}, data_t'(pu), data_t'(gpio_pullupb_o));
    post_check({name, " pulldownb"}, data_t'(pd), data_t'(gpio_pulldownb_o));
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // external sram returns read data one cycle after the address
  always @(posedge clk_i) begin : sram_model
    data_t word;
    word = ram_mem.exists(ram_addr_o) ? ram_mem[ram_addr_o] : ram_fill(ram_addr_o);
    ram_rdata_i <= word;
    if (ram_wstrb_o != '0) begin
      ram_mem[ram_addr_o] = byte_merge(word, ram_wdata_o, ram_wstrb_o);
    end
  end

  initial begin : compare_proc
    string nm;
    data_t e;
    data_t a;
    forever begin
      wait (exp_q.size() != 0);
      nm = name_q.pop_front();
      e = exp_q.pop_front();
      a = act_q.pop_front();
      assert (a === e) else begin
        value_errors++;
        $display("ERROR %s expected %h actual %h", nm, e, a);
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    addr_t addr;
    data_t wdata;
    strb_t strb;
    addr_t ram_addrs [N_RAM];
    rng = 32'h9e65;
    rst_n_i = 1'b0;
    mem_valid_i = 1'b0;
    mem_addr_i = '0;
    mem_wdata_i = '0;
    mem_wstrb_i = '0;
    ram_rdata_i = '0;
    gpio_in_i = '0;
    trap_i = 1'b0;
    irq_pin_i = 1'b0;
    irq_spi_i = 1'b0;
    clk_ext_sel_i = 1'b1;
    // top bits set so the reads show zero extension
    mfgr_id_i = 12'hc56;
    prod_id_i = 8'h91;
    mask_rev_i = 4'hb;
    next_gin = '0;
    exp_gpio = '0;
    exp_oeb = '1;
    exp_pu = '0;
    exp_pd = '0;
    {exp_pll, exp_trap, exp_irq7, exp_irq8} = '0;

    // reset values
    repeat (RST_CYCLES / 2) @(negedge clk_i);
    post_check("oeb during reset", 32'h0000_ffff, data_t'(gpio_outenb_o));
    repeat (RST_CYCLES / 2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    post_check("oeb after reset", 32'h0000_ffff, data_t'(gpio_outenb_o));
    post_check("ready after reset", 32'h0, data_t'(mem_ready_o));
    do_read("reset oeb reg", SYSCTRL_BASE + GPIO_OEB_OFS);
    do_read("reset pu reg", SYSCTRL_BASE + GPIO_PU_OFS);
    do_read("reset pd reg", SYSCTRL_BASE + GPIO_PD_OFS);
    do_read("reset pll dest", SYSCTRL_BASE + PLL_DEST_OFS);
    do_read("reset trap dest", SYSCTRL_BASE + TRAP_DEST_OFS);
    do_read("reset irq7 src", SYSCTRL_BASE + IRQ7_SRC_OFS);
    do_read("reset irq8 src", SYSCTRL_BASE + IRQ8_SRC_OFS);

    // gpio registers with random byte strobes
    for (int i = 0; i < N_REG; i++) begin
      rng = xorshift32(rng);
      addr = SYSCTRL_BASE + {rng[1:0], 2'b00};
      strb = rng[5:2];
      rng = xorshift32(rng);
      wdata = rng;
      rng = xorshift32(rng);
      next_gin = rng[15:0];
      do_write($sformatf("gpio reg 0x%02h write", addr[7:0]), addr, wdata, strb);
      do_read($sformatf("gpio reg 0x%02h read", addr[7:0]), addr);
      check_pads("gpio pads");
    end

    // sram writes then reads
    for (int i = 0; i < N_RAM; i++) begin
      rng = xorshift32(rng);
      addr = addr_t'({rng[RAM_ADDR_W+1:2], 2'b00});
      strb = (rng[20:17] == 4'h0) ? 4'hf : rng[20:17];
      ram_addrs[i] = addr;
      rng = xorshift32(rng);
      do_write($sformatf("ram write %h", addr), addr, rng, strb);
      post_check("ram strobe", data_t'(strb), data_t'(seen_wstrb));
      post_check("ram word addr", data_t'(addr[RAM_ADDR_W+1:2]), data_t'(seen_raddr));
      post_check("ram strobe in ready cycle", 32'h0, data_t'(ready_wstrb));
    end
    for (int i = 0; i < N_RAM; i++) begin
      do_read($sformatf("ram read %h", ram_addrs[i]), ram_addrs[i]);
      post_check("ram read strobe", 32'h0, data_t'(seen_wstrb));
      post_check("ram read addr", data_t'(ram_addrs[i][RAM_ADDR_W+1:2]), data_t'(seen_raddr));
    end

    // trap and pll routing where a lane 1 write leaves the selector unchanged
    do_write("trap dest lane 1", SYSCTRL_BASE + TRAP_DEST_OFS, 32'h3, 4'h2);
    check_pads("trap dest lane 1");
    for (int d = 1; d < 4; d++) begin
      do_write("trap dest", SYSCTRL_BASE + TRAP_DEST_OFS, data_t'(d), 4'h1);
      for (int lvl = 0; lvl < 2; lvl++) begin
        @(posedge clk_i);
        trap_i <= lvl[0];
        @(negedge clk_i);
        check_pads($sformatf("trap dest %0d level %0d", d, lvl));
      end
    end
    do_write("trap dest off", SYSCTRL_BASE + TRAP_DEST_OFS, 32'h0, 4'h1);
    for (int d = 1; d < 4; d++) begin
      do_write("pll dest", SYSCTRL_BASE + PLL_DEST_OFS, data_t'(d), 4'h1);
      check_pads($sformatf("pll dest %0d clock low", d));
      @(posedge clk_i);
      check_pads($sformatf("pll dest %0d clock high", d));
    end
    do_write("pll dest off", SYSCTRL_BASE + PLL_DEST_OFS, 32'h0, 4'h1);
    check_pads("pll dest off");

    // interrupt vector
    for (int s = 0; s < 4; s++) begin
      do_write("irq7 src", SYSCTRL_BASE + IRQ7_SRC_OFS, data_t'(s), 4'h1);
      do_write("irq8 src", SYSCTRL_BASE + IRQ8_SRC_OFS, data_t'(3 - s), 4'h1);
      for (int k = 0; k < 4; k++) begin
        rng = xorshift32(rng);
        next_gin = rng[15:0];
        @(posedge clk_i);
        gpio_in_i <= next_gin;
        irq_pin_i <= rng[16];
        irq_spi_i <= rng[17];
        @(negedge clk_i);
        post_check($sformatf("irq vector src %0d", s), ref_irq(next_gin, rng[16], rng[17]),
                   irq_o);
      end
    end

    // identity, clock select and unmapped space
    do_read("mfgr id", SYSCTRL_BASE + MFGR_ID_OFS);
    do_read("prod id", SYSCTRL_BASE + PROD_ID_OFS);
    do_read("mask rev", SYSCTRL_BASE + MASK_REV_OFS);
    do_read("clk sel", SYSCTRL_BASE + CLK_SEL_OFS);
    do_read("unused sysctrl offset", SYSCTRL_BASE + 32'h10);
    do_read("past ram", addr_t'(4 * MEM_WORDS));
    do_read("past sysctrl window", SYSCTRL_BASE + 32'h100);
    do_read("high unmapped", 32'hf000_0004);
    do_write("unmapped write", 32'h8000_0000, rng, 4'hf);

    wait (exp_q.size() == 0);
    #1;
    $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
    if (value_errors + proto_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
common/soc_pkg.sv
common/mem_bus_if.sv
sysctrl/sysctrl_regs.sv
sysctrl/gpio_pad_mux.sv
verilog/mem_decoder.sv
verilog/soc_fabric_top.sv
verif/tb_soc_fabric.sv

// File: Bender.yml
package:
  name: soc_fabric

sources:
  - common/soc_pkg.sv
  - common/mem_bus_if.sv
  - sysctrl/sysctrl_regs.sv
  - sysctrl/gpio_pad_mux.sv
  - verilog/mem_decoder.sv
  - verilog/soc_fabric_top.sv
  - target: test
    files:
      - verif/tb_soc_fabric.sv
